// ==== Makefile ====
# Verilator build and run of the AXI memory adapter testbench

TOP := tb_axi_adapter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== axi_adapter/axi_read_ctrl.sv ====
// read controller issuing AR and collecting R beats into a line buffer
`timescale 1ns/1ps
`include "axi_adapter_consts.svh"

module axi_read_ctrl import axi_adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  req_kind_e  kind_i,
  input  addr_t      addr_i,
  input  id_t        id_i,
  input  logic       ar_ready_i,
  input  logic       r_valid_i,
  input  logic       r_last_i,
  input  beat_t      r_data_i,
  input  id_t        r_id_i,
  output logic       ar_valid_o,
  output addr_t      ar_addr_o,
  output burst_len_t ar_len_o,
  output id_t        ar_id_o,
  output logic       r_ready_o,
  output beat_t      crit_word_o,
  output logic       crit_valid_o,
  output line_t      line_o,
  output logic       gnt_o,
  output logic       done_o,
  output logic       busy_o,
  output id_t        id_o
);

  localparam int unsigned line_offs = `ADP_BEAT_OFFS + `ADP_BEAT_IDX_W;

  rd_state_e state_q, state_d;
  req_kind_e kind_q, kind_d;
  beat_idx_t cnt_q, cnt_d;
  beat_idx_t offs_q, offs_d;
  id_t       id_q, id_d;
  line_t     line_q, line_d;
  beat_idx_t slot;

  // line reads are incrementing bursts from the line base
  always_comb begin
    ar_addr_o = addr_i;
    if (kind_i == REQ_LINE) begin
      ar_addr_o[line_offs-1:0] = '0;
    end
  end

  assign ar_len_o    = (kind_i == REQ_LINE) ? burst_len_t'(`ADP_LINE_BEATS - 1) : '0;
  assign ar_id_o     = id_i;
  assign crit_word_o = r_data_i;
  assign line_o      = line_q;
  assign id_o        = id_q;
  assign busy_o      = (state_q != RD_IDLE);
  // single reads always land in beat 0
  assign slot        = (kind_q == REQ_LINE) ? cnt_q : '0;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_d      = state_q;
    kind_d       = kind_q;
    cnt_d        = cnt_q;
    offs_d       = offs_q;
    id_d         = id_q;
    line_d       = line_q;
    ar_valid_o   = 1'b0;
    r_ready_o    = 1'b0;
    crit_valid_o = 1'b0;
    gnt_o        = 1'b0;
    done_o       = 1'b0;

    case (state_q)
      RD_IDLE: begin
        if (start_i) begin
          ar_valid_o = 1'b1;
          if (ar_ready_i) begin
            gnt_o   = 1'b1;
            kind_d  = kind_i;
            cnt_d   = '0;
            offs_d  = addr_i[`ADP_BEAT_OFFS +: `ADP_BEAT_IDX_W];
            state_d = RD_WAIT_R;
          end
        end
      end

      RD_WAIT_R: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          line_d[slot] = r_data_i;
          // beat at the requested offset is the critical word
          crit_valid_o = (kind_q == REQ_LINE) && (cnt_q == offs_q);
          cnt_d        = cnt_q + beat_idx_t'(1);
          if (r_last_i) begin
            id_d    = r_id_i;
            state_d = RD_COMPLETE;
          end
        end
      end

      RD_COMPLETE: begin
        done_o  = 1'b1;
        state_d = RD_IDLE;
      end

      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RD_IDLE;
      kind_q  <= REQ_SINGLE;
      cnt_q   <= '0;
      offs_q  <= '0;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      kind_q  <= kind_d;
      cnt_q   <= cnt_d;
      offs_q  <= offs_d;
      id_q    <= id_d;
    end
  end

  // line buffer
  always_ff @(posedge clk_i) begin
    line_q <= line_d;
  end

  // the slave only returns data for an accepted read address
  a_no_r_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == RD_IDLE) |-> !r_valid_i)
    else $error("read data arrived with no read open");

endmodule

// ==== axi_adapter/axi_write_ctrl.sv ====
// write controller sequencing AW, W and B for single-beat and line writes
`timescale 1ns/1ps
`include "axi_adapter_consts.svh"

module axi_write_ctrl import axi_adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  req_kind_e  kind_i,
  input  addr_t      addr_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  id_t        id_i,
  input  logic       aw_ready_i,
  input  logic       w_ready_i,
  input  logic       b_valid_i,
  input  id_t        b_id_i,
  output logic       aw_valid_o,
  output addr_t      aw_addr_o,
  output burst_len_t aw_len_o,
  output id_t        aw_id_o,
  output logic       w_valid_o,
  output beat_t      w_data_o,
  output strb_t      w_strb_o,
  output logic       w_last_o,
  output logic       b_ready_o,
  output logic       gnt_o,
  output logic       done_o,
  output logic       busy_o,
  output id_t        id_o
);

  localparam int unsigned line_offs = `ADP_BEAT_OFFS + `ADP_BEAT_IDX_W;
  localparam beat_idx_t   last_beat = beat_idx_t'(`ADP_LINE_BEATS - 1);

  wr_state_e state_q, state_d;
  beat_idx_t cnt_q, cnt_d;
  logic      is_line;
  logic      final_beat;

  assign is_line    = (kind_i == REQ_LINE);
  // a single write is its own last beat
  assign final_beat = !is_line || (cnt_q == last_beat);
  assign busy_o     = (state_q != WR_IDLE);

  // --------------------------------------------------
  // channel payload, held stable by the requester
  // --------------------------------------------------
  always_comb begin
    aw_addr_o = addr_i;
    if (is_line) begin
      aw_addr_o[line_offs-1:0] = '0;
    end
  end

  assign aw_len_o = is_line ? burst_len_t'(`ADP_LINE_BEATS - 1) : '0;
  assign aw_id_o  = id_i;
  assign w_data_o = wdata_i[cnt_q];
  assign w_strb_o = be_i[cnt_q];
  assign id_o     = b_id_i;

  // --------------------------------------------------
  // FSM, AW and W accepted independently
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    w_last_o   = 1'b0;
    b_ready_o  = 1'b0;
    gnt_o      = 1'b0;
    done_o     = 1'b0;

    case (state_q)
      WR_IDLE: begin
        if (start_i) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          w_last_o   = final_beat;
          case ({aw_ready_i, w_ready_i})
            2'b11: begin
              if (is_line) begin
                cnt_d   = cnt_q + beat_idx_t'(1);
                state_d = WR_WAIT_W;
              end else begin
                gnt_o   = 1'b1;
                state_d = WR_WAIT_B;
              end
            end
            2'b10: state_d = WR_WAIT_W;
            2'b01: begin
              if (is_line) begin
                cnt_d   = cnt_q + beat_idx_t'(1);
                state_d = WR_WAIT_W_AW;
              end else begin
                state_d = WR_WAIT_AW;
              end
            end
            default: state_d = WR_IDLE;
          endcase
        end
      end

      // address taken, remaining data beats go out
      WR_WAIT_W: begin
        w_valid_o = 1'b1;
        w_last_o  = final_beat;
        if (w_ready_i) begin
          if (final_beat) begin
            gnt_o   = 1'b1;
            state_d = WR_WAIT_B;
          end else begin
            cnt_d = cnt_q + beat_idx_t'(1);
          end
        end
      end

      // line write with both channels still open
      WR_WAIT_W_AW: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        w_last_o   = final_beat;
        if (w_ready_i && !final_beat) begin
          cnt_d = cnt_q + beat_idx_t'(1);
        end
        case ({aw_ready_i, w_ready_i})
          2'b11: begin
            if (final_beat) begin
              gnt_o   = 1'b1;
              state_d = WR_WAIT_B;
            end else begin
              state_d = WR_WAIT_W;
            end
          end
          2'b10: state_d = WR_WAIT_W;
          2'b01: begin
            if (final_beat) begin
              state_d = WR_WAIT_AW_LAST;
            end
          end
          default: state_d = WR_WAIT_W_AW;
        endcase
      end

      // all data is out, only the address is missing
      WR_WAIT_AW, WR_WAIT_AW_LAST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = WR_WAIT_B;
        end
      end

      WR_WAIT_B: begin
        cnt_d = '0;
        if (b_valid_i) begin
          b_ready_o = 1'b1;
          done_o    = 1'b1;
          state_d   = WR_IDLE;
        end
      end

      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WR_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // the last beat closes the data phase, earlier beats keep it open
  a_w_last_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_valid_o && w_ready_i && w_last_o) |=> !w_valid_o)
    else $error("write data still valid after the last beat");

  a_w_more_beats: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_valid_o && w_ready_i && !w_last_o) |=> w_valid_o)
    else $error("write burst stopped before the last beat");

endmodule

// ==== common/axi_adapter_consts.svh ====
// memory adapter widths and cache line geometry
`ifndef AXI_ADAPTER_CONSTS_SVH
`define AXI_ADAPTER_CONSTS_SVH

// request and AXI address width
`define ADP_ADDR_W 32

// AXI data width of one beat
`define ADP_BEAT_W 64

// line geometry, 4 beats of 8 bytes
`define ADP_LINE_BEATS 4
`define ADP_BEAT_IDX_W 2
`define ADP_BEAT_OFFS 3

// transaction id carried from request to completion
`define ADP_ID_W 4

`endif

// ==== common/axi_adapter_pkg.sv ====
// shared types and state encodings of the AXI memory adapter
`include "axi_adapter_consts.svh"

package axi_adapter_pkg;

  // request form, a single beat or a whole line
  typedef enum logic {
    REQ_SINGLE,
    REQ_LINE
  } req_kind_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT_AW,
    WR_WAIT_W,
    WR_WAIT_W_AW,
    WR_WAIT_AW_LAST,
    WR_WAIT_B
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_R,
    RD_COMPLETE
  } rd_state_e;

  // --------------------------------------------------
  // data types
  // --------------------------------------------------
  typedef logic [`ADP_ADDR_W-1:0]                           addr_t;
  typedef logic [`ADP_BEAT_W-1:0]                           beat_t;
  typedef logic [`ADP_BEAT_W/8-1:0]                         strb_t;
  typedef logic [`ADP_LINE_BEATS-1:0][`ADP_BEAT_W-1:0]      line_t;
  typedef logic [`ADP_LINE_BEATS-1:0][`ADP_BEAT_W/8-1:0]    line_strb_t;
  typedef logic [`ADP_BEAT_IDX_W-1:0]                       beat_idx_t;
  typedef logic [`ADP_ID_W-1:0]                             id_t;
  typedef logic [7:0]                                       burst_len_t;

endpackage

// ==== compile.f ====
+incdir+common
+incdir+dv
common/axi_adapter_pkg.sv
axi_adapter/axi_write_ctrl.sv
axi_adapter/axi_read_ctrl.sv
verilog/axi_request_router.sv
verilog/axi_adapter_top.sv
dv/tb_axi_adapter.sv

// ==== dv/tb_axi_adapter_tests.svh ====
// directed tests of the AXI memory adapter

task automatic test_reset_idle();
  int e0;
  e0 = errors;
  repeat (3) begin
    @(posedge clk_i);
    if (busy_o || gnt_o || valid_o) flag_error("busy, gnt or valid high after reset");
    if (aw_valid_o || w_valid_o || ar_valid_o) flag_error("AXI valid high while idle");
    if (b_ready_o || r_ready_o || crit_valid_o) begin
      flag_error("AXI ready or critical word flag high while idle");
    end
  end
  report_test("reset_idle", e0);
endtask

task automatic test_single_write_read();
  int e0;
  line_t data;
  e0 = errors;
  data = '0;
  data[0] = 64'h1122_3344_5566_7788;
  run_request(1'b1, REQ_SINGLE, 32'h0000_0048, data, 32'h0000_005a, 4'h3);
  if (last_aw_addr !== 32'h0000_0048) begin
    errors++;
    $display("FAILED aw_addr_o got %h exp %h", last_aw_addr, 32'h0000_0048);
  end
  if (last_aw_len !== 8'd0) begin
    errors++;
    $display("FAILED aw_len_o got %h exp %h", last_aw_len, 8'd0);
  end
  run_request(1'b0, REQ_SINGLE, 32'h0000_0048, '0, '0, 4'h9);
  report_test("single_write_read", e0);
endtask

task automatic test_line_write_read();
  int e0;
  line_t data;
  e0 = errors;
  for (int k = 0; k < 4; k++) data[k] = {32'hbeef_0000 + k, 32'h0bad_cafe ^ k};
  // unaligned write address, the burst still starts at the line base
  run_request(1'b1, REQ_LINE, 32'h0000_0088, data, '1, 4'h5);
  if (last_aw_addr !== 32'h0000_0080) begin
    errors++;
    $display("FAILED aw_addr_o got %h exp %h", last_aw_addr, 32'h0000_0080);
  end
  if (last_aw_len !== 8'd3) begin
    errors++;
    $display("FAILED aw_len_o got %h exp %h", last_aw_len, 8'd3);
  end
  run_request(1'b0, REQ_LINE, 32'h0000_0090, '0, '0, 4'h6);
  if (last_ar_addr !== 32'h0000_0080) begin
    errors++;
    $display("FAILED ar_addr_o got %h exp %h", last_ar_addr, 32'h0000_0080);
  end
  if (last_ar_len !== 8'd3) begin
    errors++;
    $display("FAILED ar_len_o got %h exp %h", last_ar_len, 8'd3);
  end
  report_test("line_write_read", e0);
endtask

task automatic test_critical_word();
  int e0;
  e0 = errors;
  // every beat offset of one line in turn
  for (int k = 0; k < 4; k++) begin
    run_request(1'b0, REQ_LINE, 32'h0000_0140 + 32'(k * 8), '0, '0, id_t'(k));
  end
  report_test("critical_word", e0);
endtask

task automatic test_back_pressure();
  int e0;
  line_t data;
  line_strb_t be;
  logic we;
  req_kind_e kind;
  addr_t addr;
  e0 = errors;
  heavy_stall = 1'b1;
  for (int n = 0; n < 10; n++) begin
    for (int k = 0; k < 4; k++) begin
      test_rnd = lcg_next(test_rnd);
      data[k][63:32] = test_rnd;
      test_rnd = lcg_next(test_rnd);
      data[k][31:0] = test_rnd;
    end
    test_rnd = lcg_next(test_rnd);
    be = test_rnd;
    test_rnd = lcg_next(test_rnd);
    we = test_rnd[28];
    kind = test_rnd[27] ? REQ_LINE : REQ_SINGLE;
    addr = {23'd0, test_rnd[8:3], 3'd0};
    run_request(we, kind, addr, data, be, id_t'(n));
  end
  heavy_stall = 1'b0;
  report_test("back_pressure", e0);
endtask

task automatic test_busy_timing();
  int e0;
  line_t data;
  e0 = errors;
  data = '0;
  data[0] = 64'h0f0f_0f0f_f0f0_f0f0;
  run_request(1'b1, REQ_SINGLE, 32'h0000_01f8, data, '1, 4'hc);
  run_request(1'b0, REQ_SINGLE, 32'h0000_01f8, '0, '0, 4'hd);
  run_request(1'b0, REQ_LINE, 32'h0000_01e8, '0, '0, 4'he);
  report_test("busy_timing", e0);
endtask

// ==== dv/tb_axi_adapter.sv ====
// testbench for the AXI memory adapter with an AXI slave model and memory
`timescale 1ns/1ps
`include "axi_adapter_consts.svh"

module tb_axi_adapter import axi_adapter_pkg::*; ();

  localparam int timeout_cycles = 4000;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_i, we_i;
  req_kind_e kind_i;
  addr_t addr_i;
  line_t wdata_i;
  line_strb_t be_i;
  id_t id_i;
  logic gnt_o, valid_o, crit_valid_o, busy_o;
  line_t rdata_o;
  id_t id_o, aw_id_o, ar_id_o;
  beat_t crit_word_o, w_data_o;
  logic aw_valid_o, w_valid_o, w_last_o, b_ready_o, ar_valid_o, r_ready_o;
  addr_t aw_addr_o, ar_addr_o;
  burst_len_t aw_len_o, ar_len_o;
  strb_t w_strb_o;
  // slave side inputs of the DUT
  logic aw_ready_i = 1'b0;
  logic w_ready_i = 1'b0;
  logic ar_ready_i = 1'b0;
  logic b_valid_i = 1'b0;
  logic r_valid_i = 1'b0;
  logic r_last_i = 1'b0;
  id_t b_id_i = '0;
  id_t r_id_i = '0;
  beat_t r_data_i = '0;

  // --------------------------------------------------
  // slave model state
  // --------------------------------------------------
  beat_t mem [64];
  logic [31:0] slv_rnd = 32'h7ad3bce7;
  logic heavy_stall = 1'b0;
  logic aw_seen, w_seen, b_pend, r_act;
  logic [5:0] wcnt, r_base;
  logic [1:0] r_cnt;
  burst_len_t r_len, last_ar_len, last_aw_len;
  addr_t last_ar_addr, last_aw_addr;
  id_t b_id_q, r_id_q;
  int cycle = 0;
  int r_last_cyc = 0;
  int crit_cnt = 0;
  beat_t crit_data = '0;
  int errors = 0;
  int tests_run = 0;
  beat_t ref_mem [64];
  logic [31:0] test_rnd = 32'h7ad3bce7;

  always #4 clk_i = ~clk_i;

  axi_adapter_top u_axi_adapter_top (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic beat_t fill_beat(input int idx);
    return 64'hface_0000_0000_0000 | (64'(idx) * 64'h0001_0101_0001_0101);
  endfunction

  // handshakes seen at the rising edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= fill_beat(i);
      end
      {aw_seen, w_seen, b_pend, r_act} <= '0;
      wcnt <= '0;
      r_cnt <= '0;
    end else begin
      // ready outputs follow the open bursts
      if (b_ready_o && !b_valid_i) begin
        flag_error("b_ready_o raised without b_valid_i");
      end
      if (r_ready_o !== r_act) begin
        flag_error("r_ready_o does not match the open read burst");
      end
      if (aw_valid_o && aw_ready_i) begin
        aw_seen      <= 1'b1;
        b_id_q       <= aw_id_o;
        last_aw_addr <= aw_addr_o;
        last_aw_len  <= aw_len_o;
      end
      if (w_valid_o && w_ready_i) begin
        for (int b = 0; b < 8; b++) begin
          if (w_strb_o[b]) begin
            mem[aw_addr_o[8:3] + wcnt][b*8 +: 8] <= w_data_o[b*8 +: 8];
          end
        end
        wcnt <= w_last_o ? 6'd0 : wcnt + 6'd1;
        if (w_last_o) begin
          w_seen <= 1'b1;
        end
      end
      if (aw_seen && w_seen && !b_pend) begin
        b_pend  <= 1'b1;
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
      end
      if (b_valid_i && b_ready_o) begin
        b_pend <= 1'b0;
      end
      if (ar_valid_o && ar_ready_i) begin
        r_act        <= 1'b1;
        r_cnt        <= '0;
        r_base       <= ar_addr_o[8:3];
        r_len        <= ar_len_o;
        r_id_q       <= ar_id_o;
        last_ar_addr <= ar_addr_o;
        last_ar_len  <= ar_len_o;
      end
      if (r_valid_i && r_ready_o) begin
        r_cnt <= r_cnt + 2'd1;
        if (r_last_i) begin
          r_act      <= 1'b0;
          r_last_cyc <= cycle;
        end
      end
    end
  end

  // slave outputs change on the falling edge
  always @(negedge clk_i) begin
    slv_rnd = lcg_next(slv_rnd);
    if (heavy_stall) begin
      aw_ready_i = (slv_rnd[7:5] == 3'd0);
      w_ready_i  = (slv_rnd[12:10] == 3'd0);
      ar_ready_i = (slv_rnd[17:15] == 3'd0);
    end else begin
      aw_ready_i = slv_rnd[20];
      w_ready_i  = slv_rnd[21];
      ar_ready_i = slv_rnd[22];
    end
    b_valid_i = b_pend;
    b_id_i    = b_id_q;
    r_valid_i = r_act && (slv_rnd[25:24] != 2'd0);
    r_data_i  = mem[r_base + 6'(r_cnt)];
    r_last_i  = (8'(r_cnt) == r_len);
    r_id_i    = r_id_q;
  end

  always @(posedge clk_i) begin
    if (crit_valid_o) begin
      crit_cnt  <= crit_cnt + 1;
      crit_data <= crit_word_o;
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout after %0d cycles, a transaction never completed", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic flag_error(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    $display("test %s %s", name, (errors == errs_before) ? "ok" : "had errors");
  endtask

  // one request from issue to completion, checked against ref_mem
  task automatic run_request(input logic we, input req_kind_e kind, input addr_t addr,
                             input line_t wdata, input line_strb_t be, input id_t id);
    int crit_before;
    int base;
    line_t exp_line;
    @(negedge clk_i);
    crit_before = crit_cnt;
    req_i = 1'b1;
    we_i = we;
    kind_i = kind;
    addr_i = addr;
    wdata_i = wdata;
    be_i = be;
    id_i = id;
    do @(posedge clk_i); while (!gnt_o);
    @(negedge clk_i);
    req_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (gnt_o) flag_error("second grant for one request");
      if (!busy_o) flag_error("busy low before completion");
      if (valid_o) break;
    end
    check_id("id_o", id_o, id);
    base = (kind == REQ_LINE) ? int'({addr[8:5], 2'b00}) : int'(addr[8:3]);
    if (we) begin
      for (int k = 0; k < ((kind == REQ_LINE) ? 4 : 1); k++) begin
        for (int b = 0; b < 8; b++) begin
          if (be[k][b]) ref_mem[base + k][b*8 +: 8] = wdata[k][b*8 +: 8];
        end
      end
    end else begin
      if (cycle != r_last_cyc + 1) flag_error("read completion not one cycle after last beat");
      if (kind == REQ_LINE) begin
        for (int k = 0; k < 4; k++) exp_line[k] = ref_mem[base + k];
        check_line("rdata_o", rdata_o, exp_line);
      end else begin
        check_beat("rdata_o[0]", rdata_o[0], ref_mem[base]);
      end
    end
    @(posedge clk_i);
    if (busy_o || valid_o) flag_error("busy or valid still high after completion");
    if (!we && kind == REQ_LINE) begin
      if (crit_cnt != crit_before + 1) flag_error("critical word not flagged exactly once");
      check_beat("crit_word_o", crit_data, exp_line[addr[4:3]]);
    end else if (crit_cnt != crit_before) begin
      flag_error("critical word flagged outside a line read");
    end
  endtask

  `include "tb_axi_adapter_tests.svh"

  initial begin
    for (int i = 0; i < 64; i++) ref_mem[i] = fill_beat(i);
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    kind_i = REQ_SINGLE;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    id_i = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_idle();
    test_single_write_read();
    test_line_write_read();
    test_critical_word();
    test_back_pressure();
    test_busy_timing();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/axi_adapter_top.sv ====
// AXI memory adapter top turning cache requests into AXI transactions
`timescale 1ns/1ps

module axi_adapter_top import axi_adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // request port
  input  logic       req_i,
  input  req_kind_e  kind_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  id_t        id_i,
  output logic       gnt_o,
  output logic       valid_o,
  output line_t      rdata_o,
  output id_t        id_o,
  output beat_t      crit_word_o,
  output logic       crit_valid_o,
  output logic       busy_o,
  // AW, W and B
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output addr_t      aw_addr_o,
  output burst_len_t aw_len_o,
  output id_t        aw_id_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output beat_t      w_data_o,
  output strb_t      w_strb_o,
  output logic       w_last_o,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  input  id_t        b_id_i,
  // AR and R
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output addr_t      ar_addr_o,
  output burst_len_t ar_len_o,
  output id_t        ar_id_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  beat_t      r_data_i,
  input  logic       r_last_i,
  input  id_t        r_id_i
);

  logic  wr_start, wr_gnt, wr_done, wr_busy;
  logic  rd_start, rd_gnt, rd_done, rd_busy;
  id_t   wr_id, rd_id;
  line_t rd_line;

  axi_request_router u_axi_request_router (
    .req_i      (req_i),
    .we_i       (we_i),
    .wr_gnt_i   (wr_gnt),
    .wr_done_i  (wr_done),
    .wr_busy_i  (wr_busy),
    .wr_id_i    (wr_id),
    .rd_gnt_i   (rd_gnt),
    .rd_done_i  (rd_done),
    .rd_busy_i  (rd_busy),
    .rd_id_i    (rd_id),
    .rd_line_i  (rd_line),
    .wr_start_o (wr_start),
    .rd_start_o (rd_start),
    .gnt_o      (gnt_o),
    .valid_o    (valid_o),
    .busy_o     (busy_o),
    .id_o       (id_o),
    .rdata_o    (rdata_o)
  );

  axi_write_ctrl u_axi_write_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (wr_start),
    .kind_i     (kind_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .id_i       (id_i),
    .aw_ready_i (aw_ready_i),
    .w_ready_i  (w_ready_i),
    .b_valid_i  (b_valid_i),
    .b_id_i     (b_id_i),
    .aw_valid_o (aw_valid_o),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_id_o    (aw_id_o),
    .w_valid_o  (w_valid_o),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .b_ready_o  (b_ready_o),
    .gnt_o      (wr_gnt),
    .done_o     (wr_done),
    .busy_o     (wr_busy),
    .id_o       (wr_id)
  );

  axi_read_ctrl u_axi_read_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (rd_start),
    .kind_i       (kind_i),
    .addr_i       (addr_i),
    .id_i         (id_i),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_last_i     (r_last_i),
    .r_data_i     (r_data_i),
    .r_id_i       (r_id_i),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .ar_len_o     (ar_len_o),
    .ar_id_o      (ar_id_o),
    .r_ready_o    (r_ready_o),
    .crit_word_o  (crit_word_o),
    .crit_valid_o (crit_valid_o),
    .line_o       (rd_line),
    .gnt_o        (rd_gnt),
    .done_o       (rd_done),
    .busy_o       (rd_busy),
    .id_o         (rd_id)
  );

endmodule

// ==== verilog/axi_request_router.sv ====
// request router steering to the write or read side and merging results
`timescale 1ns/1ps

module axi_request_router import axi_adapter_pkg::*; (
  input  logic  req_i,
  input  logic  we_i,
  // write side results
  input  logic  wr_gnt_i,
  input  logic  wr_done_i,
  input  logic  wr_busy_i,
  input  id_t   wr_id_i,
  // read side results
  input  logic  rd_gnt_i,
  input  logic  rd_done_i,
  input  logic  rd_busy_i,
  input  id_t   rd_id_i,
  input  line_t rd_line_i,
  // side starts
  output logic  wr_start_o,
  output logic  rd_start_o,
  // merged requester view
  output logic  gnt_o,
  output logic  valid_o,
  output logic  busy_o,
  output id_t   id_o,
  output line_t rdata_o
);

  logic side_open;

  // one transaction at a time across both sides
  assign side_open  = !(wr_busy_i || rd_busy_i);

  assign wr_start_o = req_i && we_i && side_open;
  assign rd_start_o = req_i && !we_i && side_open;

  // --------------------------------------------------
  // result merge
  // --------------------------------------------------
  assign gnt_o   = wr_gnt_i || rd_gnt_i;
  assign valid_o = wr_done_i || rd_done_i;
  assign busy_o  = wr_busy_i || rd_busy_i;

  always_comb begin
    if (rd_done_i) begin
      id_o    = rd_id_i;
      rdata_o = rd_line_i;
    end else begin
      id_o    = wr_id_i;
      rdata_o = '0;
    end
  end

  // both sides never finish together since only one is ever open
  always_comb begin
    a_done_excl: assert (!(wr_done_i && rd_done_i))
      else $error("write and read completion in the same cycle");
  end

endmodule
